//--- testbench/rv_cases.txt
// program length, then one instruction word per line (byte address in comment)
// record count, then one retire record per line: pc rd value
0000001E
00500093 // 00 addi x1, x0, 5
FFD08113 // 04 addi x2, x1, -3
402081B3 // 08 sub x3, x1, x2
00219233 // 0c sll x4, x3, x2
800002B7 // 10 lui x5, 0x80000
4022D333 // 14 sra x6, x5, x2
0022D3B3 // 18 srl x7, x5, x2
0012A433 // 1c slt x8, x5, x1
0012B4B3 // 20 sltu x9, x5, x1
0FF24513 // 24 xori x10, x4, 0xff
003565B3 // 28 or x11, x10, x3
03C5F613 // 2c andi x12, x11, 0x3c
00708013 // 30 addi x0, x1, 7
001006B3 // 34 add x13, x0, x1
00001717 // 38 auipc x14, 0x1
00208463 // 3c beq x1, x2, +8 not taken
0012C663 // 40 blt x5, x1, +12 taken
00100793 // 44 addi x15, x0, 1 skipped
00200793 // 48 addi x15, x0, 2 skipped
00C0086F // 4c jal x16, +12
00300893 // 50 addi x17, x0, 3 skipped
00400893 // 54 addi x17, x0, 4 skipped
06900913 // 58 addi x18, x0, 0x69
004909E7 // 5c jalr x19, 4(x18) to 0x6c
00500A13 // 60 addi x20, x0, 5 skipped
00600A13 // 64 addi x20, x0, 6 skipped
00700A13 // 68 addi x20, x0, 7 never fetched
40435A93 // 6c srai x21, x6, 4
FFFABB13 // 70 sltiu x22, x21, -1
0000006F // 74 jal x0, 0
00000017
00000000 01 00000005
00000004 02 00000002
00000008 03 00000003
0000000C 04 0000000C
00000010 05 80000000
00000014 06 E0000000
00000018 07 20000000
0000001C 08 00000001
00000020 09 00000000
00000024 0A 000000F3
00000028 0B 000000F3
0000002C 0C 00000030
00000030 00 00000000
00000034 0D 00000005
00000038 0E 00001038
0000003C 00 00000000
00000040 00 00000000
0000004C 10 00000050
00000058 12 00000069
0000005C 13 00000060
0000006C 15 FE000000
00000070 16 00000001
00000074 00 00000000

//--- filelist.f
+incdir+source
source/rv_pkg.sv
source/id_ex_if.sv
source/reg_file.sv
source/decode_stage.sv
source/id_ex_regs.sv
source/exec_stage.sv
source/rv_core_top.sv
testbench/tb_clock.sv
testbench/rv_core_tb.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing -j 0
TOP      := rv_core_tb
FILELIST := filelist.f
OBJ_DIR  := obj_dir
BIN      := $(OBJ_DIR)/V$(TOP)

SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)
CASES    := testbench/rv_cases.txt

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIMFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN) $(CASES)
	@out="$$(./$(BIN))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf $(OBJ_DIR)

//--- testbench/rv_core_tb.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_core_tb;

    localparam int IMEM_WORDS = 64;
    localparam int CASE_WORDS = 256;

    logic                clk;
    logic                rst_n;
    logic                stall;
    logic [31:0]         imem_data;
    logic [`RV_XLEN-1:0] imem_addr;
    logic                retire_valid;
    logic [`RV_XLEN-1:0] retire_pc;
    logic [4:0]          retire_rd;
    logic [`RV_XLEN-1:0] retire_data;

    logic [31:0] case_mem [0:CASE_WORDS-1];
    logic [31:0] imem [0:IMEM_WORDS-1];
    int          prog_len;
    int          rec_count;
    int          rec_base;      // first word of the retire records
    bit          loaded;

    tb_clock #(.PERIOD(8)) u_clock (.clk(clk));

    rv_core_top dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall        (stall),
        .imem_data    (imem_data),
        .imem_addr    (imem_addr),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

    // **************************************************************************
    // instruction memory and stall source
    // **************************************************************************
    always @(posedge clk) begin
        imem_data <= imem[imem_addr[7:2]];     // one cycle read latency
    end

    initial begin
        void'($urandom(16));
        forever begin
            @(posedge clk);
            stall <= rst_n && ($urandom % 4 == 0);  // about one cycle in four
        end
    end

    task automatic compare_word(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        if (actual !== expected) begin
            $display("ERR %s expected %08h actual %08h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_retire(input int k);
        string tag;
        tag = $sformatf("retire %0d", k);
        compare_word({tag, " pc"}, case_mem[rec_base + 3 * k], retire_pc);
        compare_word({tag, " rd"}, case_mem[rec_base + 3 * k + 1], {27'd0, retire_rd});
        compare_word({tag, " data"}, case_mem[rec_base + 3 * k + 2], retire_data);
    endtask

    task automatic load_cases();
        $readmemh("testbench/rv_cases.txt", case_mem);
        prog_len = case_mem[0];
        if ($isunknown(case_mem[0]) || prog_len < 1 || prog_len > IMEM_WORDS) begin
            $display("case file holds no usable program");
            $display("Test failed");
            $fatal(1, "bad case file");
        end
        rec_count = case_mem[prog_len + 1];
        rec_base  = prog_len + 2;
        if (rec_count < 1 || rec_base + 3 * rec_count > CASE_WORDS) begin
            $display("case file holds no usable retire records");
            $display("Test failed");
            $fatal(1, "bad case file");
        end
        // unused words are harmless addi x0 with the byte address as immediate
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = {4'd0, i[5:0], 2'b00, 13'd0, `RV_OP_OP_IMM};
        end
        for (int i = 0; i < prog_len; i++) begin
            imem[i] = case_mem[i + 1];
        end
    endtask

    // **************************************************************************
    // main sequence and retire trace checker
    // **************************************************************************
    initial begin
        int retired;
        rst_n     = 1'b0;
        stall     = 1'b0;
        imem_data = `RV_NOP;
        loaded    = 1'b0;
        retired   = 0;
        load_cases();
        loaded = 1'b1;

        @(posedge clk);
        @(negedge clk);                     // inside reset
        compare_word("reset imem_addr", `RV_RESET_PC, imem_addr);
        compare_word("reset retire_valid", 32'd0, {31'd0, retire_valid});
        @(posedge clk);
        rst_n <= 1'b1;

        while (retired < rec_count) begin
            @(negedge clk);                 // retire port settled
            if (retire_valid) begin
                check_retire(retired);
                retired++;
            end
        end

        $display("Test completed successfully");
        $finish;
    end

    // watchdog
    initial begin
        wait (loaded);
        repeat (8 * rec_count + 50) @(posedge clk);
        $display("timeout, the core stopped retiring before the end of the trace");
        $display("Test failed");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- testbench/tb_clock.sv
`timescale 1ns/1ns

module tb_clock #(
    parameter int PERIOD = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

endmodule

//--- source/rv_core_top.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module rv_core_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic [31:0]         imem_data,
    output logic [`RV_XLEN-1:0] imem_addr,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data
);

    import rv_pkg::*;

    wb_t                 wb;
    logic [4:0]          rs1_addr;
    logic [4:0]          rs2_addr;
    logic [`RV_XLEN-1:0] rs1_data;
    logic [`RV_XLEN-1:0] rs2_data;
    logic                redirect;
    logic [`RV_XLEN-1:0] redirect_pc;

    id_ex_if d_if ();   // decode side
    id_ex_if e_if ();   // execute side

    reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .rs1_addr (rs1_addr),
        .rs2_addr (rs2_addr),
        .wb       (wb),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    decode_stage u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .imem_data   (imem_data),
        .rs1_data    (rs1_data),
        .rs2_data    (rs2_data),
        .imem_addr   (imem_addr),
        .rs1_addr    (rs1_addr),
        .rs2_addr    (rs2_addr),
        .d_if        (d_if.src)
    );

    id_ex_regs u_id_ex (
        .clk    (clk),
        .rst_n  (rst_n),
        .stall  (stall),
        .in_if  (d_if.dst),
        .out_if (e_if.src)
    );

    exec_stage u_exec (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_if        (e_if.dst),
        .wb           (wb),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .retire_valid (retire_valid),
        .retire_pc    (retire_pc),
        .retire_rd    (retire_rd),
        .retire_data  (retire_data)
    );

endmodule

//--- source/exec_stage.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module exec_stage (
    input  logic                clk,
    input  logic                rst_n,
    id_ex_if.dst                ex_if,
    output rv_pkg::wb_t         wb,
    output logic                redirect,
    output logic [`RV_XLEN-1:0] redirect_pc,
    output logic                retire_valid,
    output logic [`RV_XLEN-1:0] retire_pc,
    output logic [4:0]          retire_rd,
    output logic [`RV_XLEN-1:0] retire_data
);

    import rv_pkg::*;

    alu_op_e             alu_op;
    br_cond_e            cond;
    logic [`RV_XLEN-1:0] op_a;
    logic [`RV_XLEN-1:0] op_b;
    logic [`RV_XLEN-1:0] alu_res;
    logic [`RV_XLEN-1:0] result;
    logic [4:0]          shamt;
    logic                live;
    logic                cmp;
    logic                jump;
    logic                taken;
    logic                redirect_q;

    // **************************************************************************
    // alu
    // **************************************************************************
    always_comb begin
        alu_op = ALU_ADD;
        if (ex_if.opcode == `RV_OP_LUI) begin
            alu_op = ALU_PASS_B;
        end else if (ex_if.opcode == `RV_OP_OP || ex_if.opcode == `RV_OP_OP_IMM) begin
            case (ex_if.funct3)
                3'b000: alu_op = (ex_if.opcode == `RV_OP_OP && ex_if.funct7[5]) ?
                                 ALU_SUB : ALU_ADD;
                3'b001: alu_op = ALU_SLL;
                3'b010: alu_op = ALU_SLT;
                3'b011: alu_op = ALU_SLTU;
                3'b100: alu_op = ALU_XOR;
                3'b101: alu_op = ex_if.funct7[5] ? ALU_SRA : ALU_SRL;
                3'b110: alu_op = ALU_OR;
                default: alu_op = ALU_AND;
            endcase
        end
    end

    assign op_a  = (ex_if.opcode == `RV_OP_AUIPC) ? ex_if.pc : ex_if.data1;
    assign op_b  = (ex_if.opcode == `RV_OP_OP) ? ex_if.data2 : ex_if.imm;
    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_SLL:    alu_res = op_a << shamt;
            ALU_SLT:    alu_res = {{(`RV_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {{(`RV_XLEN-1){1'b0}}, op_a < op_b};
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SRL:    alu_res = op_a >> shamt;
            ALU_SRA:    alu_res = $signed(op_a) >>> shamt;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_PASS_B: alu_res = op_b;
            default:    alu_res = op_a + op_b;
        endcase
    end

    assign jump   = ex_if.opcode == `RV_OP_JAL || ex_if.opcode == `RV_OP_JALR;
    assign result = jump ? ex_if.pc4 : alu_res;     // link address

    // **************************************************************************
    // branches and jumps
    // **************************************************************************
    assign cond = br_cond_e'(ex_if.funct3);

    always_comb begin
        case (cond)
            BR_EQ:   cmp = ex_if.data1 == ex_if.data2;
            BR_NE:   cmp = ex_if.data1 != ex_if.data2;
            BR_LT:   cmp = $signed(ex_if.data1) < $signed(ex_if.data2);
            BR_GE:   cmp = $signed(ex_if.data1) >= $signed(ex_if.data2);
            BR_LTU:  cmp = ex_if.data1 < ex_if.data2;
            BR_GEU:  cmp = ex_if.data1 >= ex_if.data2;
            default: cmp = 1'b0;
        endcase
    end

    assign live  = ex_if.valid && !ex_if.flush;
    assign taken = jump || (ex_if.opcode == `RV_OP_BRANCH && cmp);

    assign redirect_pc = (ex_if.opcode == `RV_OP_JALR) ?
                         ((ex_if.data1 + ex_if.imm) & ~32'd1) : ex_if.pc + ex_if.imm;

    // one-cycle pulse per redirect
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            redirect_q <= 1'b0;
        else
            redirect_q <= redirect;
    end

    assign redirect = live && taken && !redirect_q;

    // **************************************************************************
    // writeback and retire
    // **************************************************************************
    assign wb.valid = live && !ex_if.wr_reg_n;
    assign wb.rd    = ex_if.rd;
    assign wb.data  = result;

    assign retire_valid = live;
    assign retire_pc    = ex_if.pc;
    assign retire_rd    = ex_if.wr_reg_n ? 5'd0 : ex_if.rd;
    assign retire_data  = ex_if.wr_reg_n ? '0 : result;

endmodule

//--- source/id_ex_regs.sv
`timescale 1ns/1ns

module id_ex_regs (
    input  logic clk,
    input  logic rst_n,
    input  logic stall,
    id_ex_if.dst in_if,
    id_ex_if.src out_if
);

    // control bits get a bubble on stall
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_if.valid    <= 1'b0;
            out_if.wr_reg_n <= 1'b1;
            out_if.flush    <= 1'b0;
        end else if (stall) begin
            out_if.valid    <= 1'b0;
            out_if.wr_reg_n <= 1'b1;    // bubble never writes
            out_if.flush    <= 1'b0;
        end else begin
            out_if.valid    <= in_if.valid;
            out_if.wr_reg_n <= in_if.wr_reg_n;
            out_if.flush    <= in_if.flush;
        end
    end

    // payload held through a stall
    always_ff @(posedge clk) begin
        if (!stall) begin
            out_if.pc     <= in_if.pc;
            out_if.pc4    <= in_if.pc4;
            out_if.data1  <= in_if.data1;
            out_if.data2  <= in_if.data2;
            out_if.imm    <= in_if.imm;
            out_if.funct7 <= in_if.funct7;
            out_if.funct3 <= in_if.funct3;
            out_if.rd     <= in_if.rd;
            out_if.opcode <= in_if.opcode;
        end
    end

endmodule

//--- source/decode_stage.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module decode_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                stall,
    input  logic                redirect,
    input  logic [`RV_XLEN-1:0] redirect_pc,
    input  logic [31:0]         imem_data,
    input  logic [`RV_XLEN-1:0] rs1_data,
    input  logic [`RV_XLEN-1:0] rs2_data,
    output logic [`RV_XLEN-1:0] imem_addr,
    output logic [4:0]          rs1_addr,
    output logic [4:0]          rs2_addr,
    id_ex_if.src                d_if
);

    logic [`RV_XLEN-1:0] pc;        // fetch address
    logic [`RV_XLEN-1:0] if_pc;     // pc of the word on imem_data
    logic                discard;
    logic                held;
    logic [31:0]         held_word;
    logic [31:0]         instr;
    logic [6:0]          opcode;
    logic [4:0]          rd;
    logic                known;
    logic                is_branch;

    // **************************************************************************
    // fetch
    // **************************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc      <= `RV_RESET_PC;
            if_pc   <= `RV_RESET_PC;
            discard <= 1'b1;        // nothing fetched yet
            held    <= 1'b0;
        end else if (redirect) begin
            pc      <= redirect_pc;
            discard <= 1'b1;        // drop the word already in flight
            held    <= 1'b0;
        end else if (stall) begin
            held    <= 1'b1;
        end else begin
            pc      <= pc + 32'd4;
            if_pc   <= pc;
            discard <= 1'b0;
            held    <= 1'b0;
        end
    end

    // imem moves on during a stall, keep the first word seen
    always_ff @(posedge clk) begin
        if (stall && !held)
            held_word <= imem_data;
    end

    assign imem_addr = pc;
    assign instr     = discard ? `RV_NOP : (held ? held_word : imem_data);

    // **************************************************************************
    // decode
    // **************************************************************************
    assign opcode   = instr[6:0];
    assign rd       = instr[11:7];
    assign rs1_addr = instr[19:15];
    assign rs2_addr = instr[24:20];

    always_comb begin
        known     = 1'b1;
        is_branch = 1'b0;
        d_if.imm  = '0;
        case (opcode)
            `RV_OP_OP: ;
            `RV_OP_OP_IMM, `RV_OP_JALR:
                d_if.imm = {{20{instr[31]}}, instr[31:20]};
            `RV_OP_LUI, `RV_OP_AUIPC:
                d_if.imm = {instr[31:12], 12'b0};
            `RV_OP_JAL:
                d_if.imm = {{11{instr[31]}}, instr[31], instr[19:12],
                            instr[20], instr[30:21], 1'b0};
            `RV_OP_BRANCH: begin
                is_branch = 1'b1;
                d_if.imm  = {{19{instr[31]}}, instr[31], instr[7],
                             instr[30:25], instr[11:8], 1'b0};
            end
            default: known = 1'b0;  // unsupported, retires without a write
        endcase
    end

    assign d_if.valid    = !discard;
    assign d_if.flush    = redirect;
    assign d_if.pc       = if_pc;
    assign d_if.pc4      = if_pc + 32'd4;
    assign d_if.data1    = rs1_data;
    assign d_if.data2    = rs2_data;
    assign d_if.funct7   = instr[31:25];
    assign d_if.funct3   = instr[14:12];
    assign d_if.rd       = rd;
    assign d_if.opcode   = opcode;
    assign d_if.wr_reg_n = !known || is_branch || rd == 5'd0;

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

module reg_file (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [4:0]          rs1_addr,
    input  logic [4:0]          rs2_addr,
    input  rv_pkg::wb_t         wb,
    output logic [`RV_XLEN-1:0] rs1_data,
    output logic [`RV_XLEN-1:0] rs2_data
);

    logic [`RV_XLEN-1:0] regs [1:`RV_NREGS-1];   // x0 not stored

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `RV_NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.rd != 5'd0) begin
            regs[wb.rd] <= wb.data;
        end
    end

    function automatic logic [`RV_XLEN-1:0] read_port(input logic [4:0] addr);
        if (addr == 5'd0)
            return '0;
        if (wb.valid && wb.rd == addr)
            return wb.data;     // same-cycle write goes straight through
        return regs[addr];
    endfunction

    always_comb begin
        rs1_data = read_port(rs1_addr);
        rs2_data = read_port(rs2_addr);
    end

endmodule

//--- source/id_ex_if.sv
`timescale 1ns/1ns

`include "rv_consts.svh"

interface id_ex_if;

    logic                valid;
    logic [`RV_XLEN-1:0] pc;
    logic [`RV_XLEN-1:0] pc4;      // return address for jal/jalr
    logic [`RV_XLEN-1:0] data1;
    logic [`RV_XLEN-1:0] data2;
    logic [`RV_XLEN-1:0] imm;
    logic [6:0]          funct7;
    logic [2:0]          funct3;
    logic [4:0]          rd;
    logic [6:0]          opcode;
    logic                wr_reg_n;  // high = no register write
    logic                flush;     // killed by a redirect

    modport src (
        output valid, pc, pc4, data1, data2, imm,
        output funct7, funct3, rd, opcode, wr_reg_n, flush
    );

    modport dst (
        input valid, pc, pc4, data1, data2, imm,
        input funct7, funct3, rd, opcode, wr_reg_n, flush
    );

endinterface

//--- source/rv_pkg.sv
`include "rv_consts.svh"

package rv_pkg;

    // alu operations
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B      // lui
    } alu_op_e;

    // branch conditions, encoded as funct3
    typedef enum logic [2:0] {
        BR_EQ  = 3'b000,
        BR_NE  = 3'b001,
        BR_LT  = 3'b100,
        BR_GE  = 3'b101,
        BR_LTU = 3'b110,
        BR_GEU = 3'b111
    } br_cond_e;

    // register write from execute
    typedef struct packed {
        logic                valid;
        logic [4:0]          rd;
        logic [`RV_XLEN-1:0] data;
    } wb_t;

endpackage

//--- source/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath sizes
`define RV_XLEN         32
`define RV_NREGS        32

`define RV_RESET_PC     32'h0000_0000   // first fetch address
`define RV_NOP          32'h0000_0013   // addi x0,x0,0

// **************************************************************************
// major opcodes, instr[6:0]
// **************************************************************************
`define RV_OP_OP        7'b0110011
`define RV_OP_OP_IMM    7'b0010011
`define RV_OP_LUI       7'b0110111
`define RV_OP_AUIPC     7'b0010111
`define RV_OP_JAL       7'b1101111
`define RV_OP_JALR      7'b1100111
`define RV_OP_BRANCH    7'b1100011

`endif
